// File: src/lcd_pkg.sv
// LCD controller shared definitions
package lcd_pkg;

    typedef logic [15:0] pixel_t;      // rgb565
    typedef logic [7:0]  byte_t;       // spi payload byte
    typedef logic [6:0]  rom_addr_t;   // 128 rom entries
    typedef logic [9:0]  rom_word_t;   // {opcode, argument}
    typedef logic [6:0]  cmd_len_t;    // entries per sequence

    // rom opcode in bits 9:8 of each entry
    typedef enum logic [1:0] {
        op_reg_addr  = 2'd0,   // register address, sent with dc low
        op_data_byte = 2'd1,   // register data, sent with dc high
        op_delay_ms  = 2'd2,   // argument is the delay in ms
        op_reset_pin = 2'd3    // argument bit 0 set asserts the pin
    } cmd_op_t;

    typedef struct packed {
        logic  dc;     // low for command, high for data
        byte_t data;
    } lcd_word_t;

    typedef struct packed {
        pixel_t tdata;
        logic   tvalid;
        logic   tuser;   // last pixel of frame
    } stream_t;

    localparam rom_addr_t init_seq_addr     = 7'd0;
    localparam cmd_len_t  init_seq_len      = 7'd56;
    localparam rom_addr_t frame_seq_addr    = 7'd56;   // window set and memory write
    localparam cmd_len_t  frame_seq_len     = 7'd11;
    localparam pixel_t    transparent_color = 16'hFFFF;
    localparam string     rom_file          = "src/lcd_cmd_rom.hex";
    localparam int        word_bits         = 9;       // dc plus one byte

endpackage

// File: src/lcd_cmd_rom.sv
// Command sequence ROM
module lcd_cmd_rom (
    input  logic               s_axis_aclk,
    input  lcd_pkg::rom_addr_t addr,
    output lcd_pkg::rom_word_t dout
);
    import lcd_pkg::*;

    rom_word_t mem [0:(2**$bits(rom_addr_t))-1];

    initial begin
        for (int i = 0; i < 2**$bits(rom_addr_t); i++) begin
            mem[i] = '0;   // unused tail reads as a register address of zero
        end
        $readmemh(rom_file, mem);
    end

    always_ff @(posedge s_axis_aclk) begin
        dout <= mem[addr];   // one cycle read latency
    end

endmodule

// File: src/lcd_spi_tx.sv
// 9-bit SPI serializer
module lcd_spi_tx (
    input  logic               s_axis_aclk,
    input  logic               s_axis_aresetn,
    input  logic               tx_start,
    input  lcd_pkg::lcd_word_t tx_word,
    output logic               tx_busy,
    output logic               lcd_spi_scl,
    output logic               lcd_spi_sda
);
    import lcd_pkg::*;

    logic [word_bits-1:0]         shift_q;   // msb is on the line
    logic [$clog2(word_bits)-1:0] bit_cnt;
    logic                         phase;     // 0 = scl low half, 1 = scl high half

    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            tx_busy <= 1'b0;
            shift_q <= '0;
            bit_cnt <= '0;
            phase   <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                shift_q <= tx_word;   // dc goes out first
                bit_cnt <= '0;
            end
        end else begin
            phase <= ~phase;
            if (phase) begin   // end of high half, move to next bit
                shift_q <= {shift_q[word_bits-2:0], 1'b0};
                bit_cnt <= bit_cnt + 1'b1;
                if (int'(bit_cnt) == word_bits - 1) begin
                    tx_busy <= 1'b0;   // 18 cycles after start
                end
            end
        end
    end

    assign lcd_spi_scl = phase;
    assign lcd_spi_sda = shift_q[word_bits-1];   // idles low once shifted out

    // requesters must hold off until the serializer is free
    a_no_start_while_busy: assert property (@(posedge s_axis_aclk) disable iff (!s_axis_aresetn)
        tx_busy |-> !tx_start);

endmodule

// File: src/lcd_cmd_seq.sv
// Command sequence player
module lcd_cmd_seq #(
    parameter int ms_ticks = 25000
) (
    input  logic               s_axis_aclk,
    input  logic               s_axis_aresetn,
    input  logic               seq_start,
    input  lcd_pkg::rom_addr_t seq_addr,
    input  lcd_pkg::cmd_len_t  seq_len,
    output logic               seq_done,
    input  logic               tx_busy,
    output logic               tx_start,
    output lcd_pkg::lcd_word_t tx_word,
    output logic               lcd_resetn
);
    import lcd_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_fetch,    // rom address presented
        s_decode,   // rom data valid
        s_send,
        s_wait,
        s_delay
    } state_t;

    state_t    state;
    rom_addr_t addr_q;
    cmd_len_t  left_q;      // entries still to play, current one included
    rom_word_t rom_dout;
    cmd_op_t   op;
    byte_t     arg;
    byte_t     delay_cnt;
    logic      entry_end;
    logic      last_entry;
    logic [31:0] ms_cnt;
    logic        ms_tick;

    lcd_cmd_rom rom0 (
        .s_axis_aclk (s_axis_aclk),
        .addr        (addr_q),
        .dout        (rom_dout)
    );

    assign op         = cmd_op_t'(rom_dout[9:8]);
    assign arg        = rom_dout[7:0];
    assign last_entry = (left_q == cmd_len_t'(1));
    assign tx_start   = (state == s_send);
    assign ms_tick    = (ms_cnt == 32'(ms_ticks - 1));

    // an entry finishes here, whatever its opcode
    assign entry_end = ((state == s_decode) && (op == op_reset_pin))
                    || ((state == s_wait) && !tx_busy)
                    || ((state == s_delay) && (delay_cnt == '0));

    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            ms_cnt <= '0;
        end else begin
            ms_cnt <= ms_tick ? '0 : ms_cnt + 1'b1;   // free running, not aligned to delays
        end
    end

    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            state      <= s_idle;
            addr_q     <= '0;
            left_q     <= '0;
            seq_done   <= 1'b0;
            lcd_resetn <= 1'b0;
        end else begin
            seq_done <= entry_end && last_entry;
            if ((state == s_decode) && (op == op_reset_pin)) begin
                lcd_resetn <= ~arg[0];
            end
            if (entry_end) begin
                addr_q <= addr_q + 1'b1;
                left_q <= left_q - 1'b1;
                state  <= last_entry ? s_idle : s_fetch;
            end else begin
                case (state)
                    s_idle: if (seq_start) begin
                        addr_q <= seq_addr;
                        left_q <= seq_len;
                        state  <= s_fetch;
                    end
                    s_fetch:  state <= s_decode;
                    s_decode: state <= (op == op_delay_ms) ? s_delay : s_send;
                    s_send:   state <= s_wait;   // busy is up from the next cycle
                    default:  state <= state;
                endcase
            end
        end
    end

    always_ff @(posedge s_axis_aclk) begin
        if (state == s_decode) begin
            tx_word.dc   <= (op == op_data_byte);
            tx_word.data <= arg;
            delay_cnt    <= arg;
        end else if ((state == s_delay) && ms_tick && (delay_cnt != '0)) begin
            delay_cnt <= delay_cnt - 1'b1;   // one per ms tick
        end
    end

endmodule

// File: src/lcd_pixel_mux.sv
// OSD over image pixel merger
module lcd_pixel_mux (
    input  logic               s_axis_aclk,
    input  logic               s_axis_aresetn,
    input  logic               frame_start,
    output logic               frame_done,
    input  lcd_pkg::stream_t   img_in,
    input  lcd_pkg::stream_t   osd_in,
    output logic               img_tready,
    output logic               osd_tready,
    input  logic               tx_busy,
    output logic               tx_start,
    output lcd_pkg::lcd_word_t tx_word
);
    import lcd_pkg::*;

    typedef enum logic [1:0] {s_idle, s_accept, s_hi_wait, s_lo_wait} state_t;

    state_t state;
    pixel_t sel_pix;
    byte_t  lo_q;     // low byte waits for the high one to finish
    logic   last_q;
    logic   take;

    assign sel_pix = (osd_in.tdata == transparent_color) ? img_in.tdata : osd_in.tdata;
    assign take    = (state == s_accept) && img_in.tvalid && osd_in.tvalid && !tx_busy;

    assign img_tready = take;   // both streams advance together
    assign osd_tready = take;
    assign tx_start   = take || ((state == s_hi_wait) && !tx_busy);
    assign tx_word    = '{dc: 1'b1, data: (state == s_accept) ? sel_pix[15:8] : lo_q};

    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            state      <= s_idle;
            last_q     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                s_idle: if (frame_start) begin
                    last_q <= 1'b0;
                    state  <= s_accept;
                end
                s_accept: if (take) begin
                    last_q <= img_in.tuser && osd_in.tuser;   // joint end of frame
                    state  <= s_hi_wait;
                end
                s_hi_wait: if (!tx_busy) state <= s_lo_wait;   // low byte starts here
                s_lo_wait: if (!tx_busy) begin
                    frame_done <= last_q;
                    state      <= last_q ? s_idle : s_accept;
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge s_axis_aclk) begin
        if (take) lo_q <= sel_pix[7:0];
    end

    // the serializer takes the high byte on the handshake cycle
    a_hi_byte_taken: assert property (@(posedge s_axis_aclk) disable iff (!s_axis_aresetn)
        img_tready |=> tx_busy);

endmodule

// File: src/lcd_ctrl.sv
// LCD controller top level
module lcd_ctrl #(
    parameter int ms_ticks = 25000
) (
    input  logic             s_axis_aclk,
    input  logic             s_axis_aresetn,
    input  lcd_pkg::stream_t img_in,
    input  lcd_pkg::stream_t osd_in,
    output logic             img_tready,
    output logic             osd_tready,
    output logic             lcd_spi_scl,
    output logic             lcd_spi_sda,
    output logic             lcd_resetn
);
    import lcd_pkg::*;

    typedef enum logic [2:0] {
        st_reset, st_init, st_img_sync, st_osd_sync, st_frame_seq, st_frame_fill
    } state_t;

    state_t    state;
    logic      seq_start, seq_done, frame_start, frame_done;
    rom_addr_t seq_addr;
    cmd_len_t  seq_len;
    logic      sync_img_tready, sync_osd_tready, mux_img_tready, mux_osd_tready;
    logic      seq_tx_start, mux_tx_start, tx_start, tx_busy;
    lcd_word_t seq_tx_word, mux_tx_word, tx_word;

    assign seq_addr   = (state == st_init) ? init_seq_addr : frame_seq_addr;
    assign seq_len    = (state == st_init) ? init_seq_len : frame_seq_len;
    assign img_tready = sync_img_tready | mux_img_tready;
    assign osd_tready = sync_osd_tready | mux_osd_tready;
    assign tx_start   = (state == st_frame_fill) ? mux_tx_start : seq_tx_start;
    assign tx_word    = (state == st_frame_fill) ? mux_tx_word : seq_tx_word;

    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            state           <= st_reset;
            seq_start       <= 1'b0;
            frame_start     <= 1'b0;
            sync_img_tready <= 1'b0;
            sync_osd_tready <= 1'b0;
        end else begin
            seq_start   <= 1'b0;
            frame_start <= 1'b0;
            case (state)
                st_reset: begin
                    seq_start <= 1'b1;
                    state     <= st_init;
                end
                st_init: if (seq_done) state <= st_img_sync;
                st_img_sync: begin   // drop the partial image frame
                    sync_img_tready <= 1'b1;
                    if (img_in.tvalid && sync_img_tready && img_in.tuser) begin
                        sync_img_tready <= 1'b0;
                        state           <= st_osd_sync;
                    end
                end
                st_osd_sync: begin
                    sync_osd_tready <= 1'b1;
                    if (osd_in.tvalid && sync_osd_tready && osd_in.tuser) begin
                        sync_osd_tready <= 1'b0;
                        seq_start       <= 1'b1;
                        state           <= st_frame_seq;
                    end
                end
                st_frame_seq: if (seq_done) begin
                    frame_start <= 1'b1;
                    state       <= st_frame_fill;
                end
                st_frame_fill: if (frame_done) begin
                    seq_start <= 1'b1;   // window set again for the next frame
                    state     <= st_frame_seq;
                end
                default: state <= st_reset;
            endcase
        end
    end

    lcd_cmd_seq #(.ms_ticks(ms_ticks)) seq0 (
        .s_axis_aclk    (s_axis_aclk),
        .s_axis_aresetn (s_axis_aresetn),
        .seq_start      (seq_start),
        .seq_addr       (seq_addr),
        .seq_len        (seq_len),
        .seq_done       (seq_done),
        .tx_busy        (tx_busy),
        .tx_start       (seq_tx_start),
        .tx_word        (seq_tx_word),
        .lcd_resetn     (lcd_resetn)
    );

    lcd_pixel_mux mux0 (
        .s_axis_aclk    (s_axis_aclk),
        .s_axis_aresetn (s_axis_aresetn),
        .frame_start    (frame_start),
        .frame_done     (frame_done),
        .img_in         (img_in),
        .osd_in         (osd_in),
        .img_tready     (mux_img_tready),
        .osd_tready     (mux_osd_tready),
        .tx_busy        (tx_busy),
        .tx_start       (mux_tx_start),
        .tx_word        (mux_tx_word)
    );

    lcd_spi_tx tx0 (
        .s_axis_aclk    (s_axis_aclk),
        .s_axis_aresetn (s_axis_aresetn),
        .tx_start       (tx_start),
        .tx_word        (tx_word),
        .tx_busy        (tx_busy),
        .lcd_spi_scl    (lcd_spi_scl),
        .lcd_spi_sda    (lcd_spi_sda)
    );

    // sync treadys are released before the merger takes over
    a_tready_pair: assert property (@(posedge s_axis_aclk) disable iff (!s_axis_aresetn)
        (state == st_frame_fill) |-> (img_tready == osd_tready));

endmodule

// File: sim/tb_lcd_ctrl.sv
// LCD controller testbench
module tb_lcd_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import lcd_pkg::*;

    localparam int ms_ticks      = 4;
    localparam int frame_pixels  = 8;
    localparam int shown_frames  = 3;                              // stream frames 1 to 3
    localparam int stream_pixels = (shown_frames + 2) * frame_pixels;   // spare frame at the end
    localparam int init_words    = 52;
    localparam int reset_cycles  = 2;
    localparam int reset_hold    = (5 - 1) * ms_ticks;   // 5 ms pulse less one timer phase
    localparam int reset_gap     = 120 * ms_ticks;
    localparam int max_cycles    = 20000;   // run needs about 4k cycles

    logic    s_axis_aclk    = 1'b0;
    logic    s_axis_aresetn = 1'b0;
    stream_t img_in         = '0;
    stream_t osd_in         = '0;
    logic    img_tready;
    logic    osd_tready;
    logic    lcd_spi_scl;
    logic    lcd_spi_sda;
    logic    lcd_resetn;

    rom_word_t rom [0:127];
    pixel_t    img_pix [0:stream_pixels-1];
    pixel_t    osd_pix [0:stream_pixels-1];
    lcd_word_t exp_q [$];

    int img_idx      = 0;
    int osd_idx      = 0;
    int cycle        = 0;
    int checked      = 0;
    int rx_bits      = 0;
    int resetn_cycle = 0;
    int value_errors = 0;   // monitor side
    int other_errors = 0;
    int end_errors   = 0;   // main sequence side
    logic [word_bits-1:0] rx_shift = '0;
    logic scl_q       = 1'b0;
    logic resetn_seen = 1'b0;
    logic scl_seen    = 1'b0;

    lcd_ctrl #(.ms_ticks(ms_ticks)) dut0 (
        .s_axis_aclk    (s_axis_aclk),
        .s_axis_aresetn (s_axis_aresetn),
        .img_in         (img_in),
        .osd_in         (osd_in),
        .img_tready     (img_tready),
        .osd_tready     (osd_tready),
        .lcd_spi_scl    (lcd_spi_scl),
        .lcd_spi_sda    (lcd_spi_sda),
        .lcd_resetn     (lcd_resetn)
    );

    initial begin
        forever #20 s_axis_aclk = ~s_axis_aclk;
    end

    task automatic make_pixels();
        for (int i = 0; i < stream_pixels; i++) begin
            img_pix[i] = pixel_t'($urandom);
            if ($urandom_range(1) == 0) begin
                osd_pix[i] = transparent_color;
            end else begin
                osd_pix[i] = pixel_t'($urandom_range(32'hFFFE));   // any opaque colour
            end
        end
    endtask

    // word entries go on the line, delay and reset entries do not
    task automatic queue_entry(input rom_word_t e);
        if (e[9:8] == op_reg_addr) begin
            exp_q.push_back({1'b0, e[7:0]});
        end else if (e[9:8] == op_data_byte) begin
            exp_q.push_back({1'b1, e[7:0]});
        end
    endtask

    task automatic build_model();
        pixel_t px;
        int     n;
        for (int i = 0; i < int'(init_seq_len); i++) begin
            queue_entry(rom[int'(init_seq_addr) + i]);
        end
        if (exp_q.size() != init_words) begin
            end_errors++;
            $display("hex file holds %0d init words where %0d are expected",
                     exp_q.size(), init_words);
        end
        for (int f = 1; f <= shown_frames; f++) begin
            for (int i = 0; i < int'(frame_seq_len); i++) begin
                queue_entry(rom[int'(frame_seq_addr) + i]);
            end
            for (int p = 0; p < frame_pixels; p++) begin
                n  = f * frame_pixels + p;
                px = (osd_pix[n] == transparent_color) ? img_pix[n] : osd_pix[n];
                exp_q.push_back({1'b1, px[15:8]});   // high byte first
                exp_q.push_back({1'b1, px[7:0]});
            end
        end
    endtask

    function automatic stream_t next_beat(input pixel_t data, input int n);
        stream_t b;
        b.tdata  = data;
        b.tvalid = (n < stream_pixels) && ($urandom_range(3) != 0);   // random gaps
        b.tuser  = (n % frame_pixels) == frame_pixels - 1;
        return b;
    endfunction

    task automatic check_word(input lcd_word_t got);
        lcd_word_t want;
        if (exp_q.size() == 0) begin
            return;   // frames past the last modelled one
        end
        want = exp_q.pop_front();
        checked++;
        if (got !== want) begin
            value_errors++;
            $display("ERROR lcd_spi_sda word %0d: got 0x%03h expected 0x%03h", checked, got, want);
        end
    endtask

    always @(posedge s_axis_aclk) begin : drive_img
        int n;
        n = img_idx;
        if (img_in.tvalid && img_tready) begin
            n++;
        end
        if (s_axis_aresetn && !(img_in.tvalid && !img_tready)) begin   // hold an unaccepted beat
            img_in <= next_beat(img_pix[n % stream_pixels], n);
        end
        img_idx <= n;
    end

    always @(posedge s_axis_aclk) begin : drive_osd
        int n;
        n = osd_idx;
        if (osd_in.tvalid && osd_tready) begin
            n++;
        end
        if (s_axis_aresetn && !(osd_in.tvalid && !osd_tready)) begin
            osd_in <= next_beat(osd_pix[n % stream_pixels], n);
        end
        osd_idx <= n;
    end

    always @(posedge s_axis_aclk) begin : monitor
        lcd_word_t word;
        cycle++;
        scl_q <= lcd_spi_scl;
        if (s_axis_aresetn) begin
            if (lcd_resetn && !resetn_seen) begin
                resetn_seen  <= 1'b1;
                resetn_cycle <= cycle;
                if (cycle - reset_cycles < reset_hold) begin
                    other_errors++;
                    $display("panel reset pin released only %0d cycles after reset",
                             cycle - reset_cycles);
                end
            end
            if (lcd_spi_scl && !scl_q) begin
                if (!resetn_seen) begin
                    other_errors++;
                    $display("SCL rose while the panel reset pin was still asserted");
                end else if (!scl_seen && (cycle - resetn_cycle < reset_gap)) begin
                    other_errors++;
                    $display("only %0d cycles from panel reset release to the first SCL edge",
                             cycle - resetn_cycle);
                end
                scl_seen <= 1'b1;
                word     = {rx_shift[word_bits-2:0], lcd_spi_sda};   // msb first
                rx_shift <= word;
                if (rx_bits == word_bits - 1) begin
                    rx_bits = 0;
                    check_word(word);
                end else begin
                    rx_bits++;
                end
            end
            if ((checked < init_words) && (img_tready || osd_tready)) begin
                other_errors++;
                $display("ERROR img_tready 0x%h osd_tready 0x%h during the init sequence",
                         img_tready, osd_tready);
            end
            if ((img_idx >= frame_pixels) && (osd_idx >= frame_pixels)) begin   // fill phase
                if (img_tready != osd_tready) begin
                    value_errors++;
                    $display("ERROR img_tready 0x%h osd_tready 0x%h", img_tready, osd_tready);
                end
                if (img_tready && !(img_in.tvalid && osd_in.tvalid)) begin
                    value_errors++;
                    $display("ERROR img_tready 0x%h with tvalid img 0x%h osd 0x%h",
                             img_tready, img_in.tvalid, osd_in.tvalid);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h633c));
        for (int i = 0; i < 128; i++) begin
            rom[i] = '0;
        end
        $readmemh(rom_file, rom);
        make_pixels();
        build_model();

        repeat (reset_cycles) @(posedge s_axis_aclk);
        s_axis_aresetn <= 1'b1;
        @(negedge s_axis_aclk);
        if (lcd_resetn !== 1'b0 || lcd_spi_scl !== 1'b0 || lcd_spi_sda !== 1'b0
                || img_tready !== 1'b0 || osd_tready !== 1'b0) begin
            end_errors++;
            $display("ERROR after reset lcd_resetn 0x%h lcd_spi_scl 0x%h lcd_spi_sda 0x%h",
                     lcd_resetn, lcd_spi_scl, lcd_spi_sda);
            $display("ERROR after reset img_tready 0x%h osd_tready 0x%h",
                     img_tready, osd_tready);
        end

        while (exp_q.size() != 0 && cycle < max_cycles) begin
            @(negedge s_axis_aclk);
        end
        if (exp_q.size() != 0) begin
            end_errors++;
            $display("timed out after %0d cycles with %0d words never received",
                     cycle, exp_q.size());
        end

        $display("words checked %0d, value errors %0d, other errors %0d",
                 checked, value_errors, other_errors + end_errors);
        if (value_errors + other_errors + end_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sources.f
src/lcd_pkg.sv
src/lcd_cmd_rom.sv
src/lcd_spi_tx.sv
src/lcd_cmd_seq.sv
src/lcd_pixel_mux.sv
src/lcd_ctrl.sv
sim/tb_lcd_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the LCD controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_lcd_ctrl -f sources.f

output=$(./obj_dir/Vtb_lcd_ctrl)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1

// File: src/lcd_cmd_rom.hex
// columns: opcode in bits 9:8 (0 reg addr, 1 data, 2 delay ms, 3 reset pin), argument in 7:0
301 // panel reset asserted
205
300 // panel reset released
278 // 120 ms wake-up time
0CF
100
1C1
130
0ED
164
103
112
181
0E8
185
100
178
0CB
139
12C
100
134
102
0F7
120
0EA
100
100
0C0
123
0C1
110
0C5
13E
128
0C7
186
036
148
03A
155
0B1
100
118
0B6
108
182
127
0F2
100
026
101
011 // sleep out
029 // display on
013
020
02A // frame sequence, column window 0 to 239
100
100
100
1EF
02B // row window 0 to 319
100
100
101
13F
02C // memory write, pixels follow
